/* verilog/soc_bus_consts.svh */
// Bus widths, fixed data words and the address map of the system bus crossbar.
// Region macros are base/mask pairs over the tagged address {io_tag, word_addr[18:0]}.
`ifndef SOC_BUS_CONSTS_SVH
`define SOC_BUS_CONSTS_SVH

// Field widths
`define WORD_W 16
`define ADDR_W 20
`define SEL_W 2
`define IID_W 3
`define SW_W 10
`define LED_W 14

// Unmapped I/O reads back as all ones
`define DEFAULT_DATA 16'hffff

// Upper bits of the interrupt vector word, iid fills the rest
`define INTA_PREFIX 13'd1

// Memory map, bit 19 is the I/O tag, bits 18:0 are byte address bits 19:1
`define FLASH_A 20'b0_1111_0000_0000_0000_000
`define FLASH_M 20'b1_1111_0000_0000_0000_000
`define BIOS_A 20'b0_1100_0000_0000_0000_000
`define BIOS_M 20'b1_1111_0000_0000_0000_000
`define VMEM_A 20'b0_1010_0000_0000_0000_000
`define VMEM_M 20'b1_1110_0000_0000_0000_000
`define VIO_A 20'b1_0000_0000_0011_1100_000
`define VIO_M 20'b1_0000_1111_1111_1110_000
`define UART_A 20'b1_0000_0000_0011_1111_100
`define UART_M 20'b1_0000_1111_1111_1111_100
`define GPIO_A 20'b1_0000_1111_0001_0000_000
`define GPIO_M 20'b1_0000_1111_1111_1111_110
// Catch-all for any memory access
`define MEM_A 20'b0_0000_0000_0000_0000_000
`define MEM_M 20'b1_0000_0000_0000_0000_000

`endif

/* verilog/soc_bus_pkg.sv */
// Shared types of the system bus crossbar.
// Imported by every RTL module of the bus.
`include "soc_bus_consts.svh"

package soc_bus_pkg;

  // Bus data word
  typedef logic [`WORD_W-1:0] word_t;

  // Tagged address, top bit set for I/O space
  typedef logic [`ADDR_W-1:0] addr_t;

  // Byte selects
  typedef logic [`SEL_W-1:0] sel_t;

  // Owner of a decoded address, default answers unmapped accesses
  typedef enum logic [2:0] {
    SLV_FLASH,
    SLV_VIDEO,
    SLV_UART,
    SLV_GPIO,
    SLV_MEM,
    SLV_DEFAULT
  } slave_idx_t;

endpackage

/* verilog/bus_decode.sv */
// Address decoder of the crossbar.
// Maps the tagged master address to the slave that owns it, first match wins.
`include "soc_bus_consts.svh"

module bus_decode import soc_bus_pkg::*; (
  input  addr_t      m_adr_i,
  output slave_idx_t sel_idx_o
);

  logic hit_flash;
  logic hit_bios;
  logic hit_vmem;
  logic hit_vio;
  logic hit_uart;
  logic hit_gpio;
  logic hit_mem;

  // Address and base agree on every bit the mask sets
  function automatic logic region_hit(input addr_t adr, input addr_t base,
                                      input addr_t mask);
    region_hit = ((adr ^ base) & mask) == '0;
  endfunction

  assign hit_flash = region_hit(m_adr_i, `FLASH_A, `FLASH_M);
  assign hit_bios  = region_hit(m_adr_i, `BIOS_A, `BIOS_M);
  assign hit_vmem  = region_hit(m_adr_i, `VMEM_A, `VMEM_M);
  assign hit_vio   = region_hit(m_adr_i, `VIO_A, `VIO_M);
  assign hit_uart  = region_hit(m_adr_i, `UART_A, `UART_M);
  assign hit_gpio  = region_hit(m_adr_i, `GPIO_A, `GPIO_M);
  assign hit_mem   = region_hit(m_adr_i, `MEM_A, `MEM_M);

  // Priority chain, the BIOS shadow also lives in flash
  always_comb begin
    if (hit_flash || hit_bios) begin
      sel_idx_o = SLV_FLASH;
    end else if (hit_vmem || hit_vio) begin
      sel_idx_o = SLV_VIDEO;
    end else if (hit_uart) begin
      sel_idx_o = SLV_UART;
    end else if (hit_gpio) begin
      sel_idx_o = SLV_GPIO;
    end else if (hit_mem) begin
      sel_idx_o = SLV_MEM;
    end else begin
      // Unmapped I/O
      sel_idx_o = SLV_DEFAULT;
    end
  end

endmodule

/* verilog/bus_route.sv */
// Request dispatch of the crossbar.
// Steers cycle and strobe to the decoded slave and acts as the default slave.
module bus_route import soc_bus_pkg::*; (
  input  slave_idx_t sel_idx_i,
  input  logic       m_cyc_i,
  input  logic       m_stb_i,

  output logic       flash_cyc_o,
  output logic       flash_stb_o,
  output logic       video_cyc_o,
  output logic       video_stb_o,
  output logic       uart_cyc_o,
  output logic       uart_stb_o,
  output logic       mem_cyc_o,
  output logic       mem_stb_o,
  output logic       gpio_cyc_o,
  output logic       gpio_stb_o,

  output logic       def_ack_o
);

  logic sel_flash;
  logic sel_video;
  logic sel_uart;
  logic sel_mem;
  logic sel_gpio;
  logic sel_def;

  // One-hot view of the decoded index
  always_comb begin
    sel_flash = 1'b0;
    sel_video = 1'b0;
    sel_uart  = 1'b0;
    sel_mem   = 1'b0;
    sel_gpio  = 1'b0;
    sel_def   = 1'b0;
    case (sel_idx_i)
      SLV_FLASH: sel_flash = 1'b1;
      SLV_VIDEO: sel_video = 1'b1;
      SLV_UART:  sel_uart  = 1'b1;
      SLV_GPIO:  sel_gpio  = 1'b1;
      SLV_MEM:   sel_mem   = 1'b1;
      default:   sel_def   = 1'b1;
    endcase
  end

  // Only the owner sees the cycle, so idle master means idle slaves
  assign flash_cyc_o = m_cyc_i & sel_flash;
  assign flash_stb_o = m_stb_i & sel_flash;
  assign video_cyc_o = m_cyc_i & sel_video;
  assign video_stb_o = m_stb_i & sel_video;
  assign uart_cyc_o  = m_cyc_i & sel_uart;
  assign uart_stb_o  = m_stb_i & sel_uart;
  assign mem_cyc_o   = m_cyc_i & sel_mem;
  assign mem_stb_o   = m_stb_i & sel_mem;
  assign gpio_cyc_o  = m_cyc_i & sel_gpio;
  assign gpio_stb_o  = m_stb_i & sel_gpio;

  // Default slave completes with zero wait states
  assign def_ack_o = m_cyc_i & m_stb_i & sel_def;

endmodule

/* verilog/gpio_regs.sv */
// Switches and LEDs register slave.
// Word 0 reads the switches, word 1 holds the LED register.
`include "soc_bus_consts.svh"

module gpio_regs import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_lck,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic              adr_i,
  input  word_t             dat_i,
  input  logic [`SW_W-1:0]  sw_i,
  output word_t             dat_o,
  output logic              ack_o,
  output logic [`LED_W-1:0] leds_o
);

  logic [`LED_W-1:0] leds_q;

  // Zero wait states
  assign ack_o = cyc_i & stb_i;

  always_comb begin
    if (adr_i) begin
      dat_o = {{(`WORD_W-`LED_W){1'b0}}, leds_q};
    end else begin
      dat_o = {{(`WORD_W-`SW_W){1'b0}}, sw_i};
    end
  end

  // Switch word is read only
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      leds_q <= '0;
    end else if (ack_o && we_i && adr_i) begin
      leds_q <= dat_i[`LED_W-1:0];
    end
  end

  assign leds_o = leds_q;

endmodule

/* verilog/read_return.sv */
// Read data and acknowledge return path of the crossbar.
// Muxes the selected slave back to the master, with the interrupt vector override.
`include "soc_bus_consts.svh"

module read_return import soc_bus_pkg::*; (
  input  slave_idx_t        sel_idx_i,
  input  word_t             flash_dat_i,
  input  logic              flash_ack_i,
  input  word_t             video_dat_i,
  input  logic              video_ack_i,
  input  word_t             uart_dat_i,
  input  logic              uart_ack_i,
  input  word_t             mem_dat_i,
  input  logic              mem_ack_i,
  input  word_t             gpio_dat_i,
  input  logic              gpio_ack_i,
  input  logic              def_ack_i,
  input  logic              inta_i,
  input  logic [`IID_W-1:0] iid_i,
  output word_t             m_dat_o,
  output logic              m_ack_o
);

  word_t slv_dat;

  always_comb begin
    case (sel_idx_i)
      SLV_FLASH: begin
        slv_dat = flash_dat_i;
        m_ack_o = flash_ack_i;
      end
      SLV_VIDEO: begin
        slv_dat = video_dat_i;
        m_ack_o = video_ack_i;
      end
      SLV_UART: begin
        slv_dat = uart_dat_i;
        m_ack_o = uart_ack_i;
      end
      SLV_GPIO: begin
        slv_dat = gpio_dat_i;
        m_ack_o = gpio_ack_i;
      end
      SLV_MEM: begin
        slv_dat = mem_dat_i;
        m_ack_o = mem_ack_i;
      end
      default: begin
        slv_dat = `DEFAULT_DATA;
        m_ack_o = def_ack_i;
      end
    endcase
  end

  // Interrupt acknowledge cycle reads the vector, not the slave
  assign m_dat_o = inta_i ? {`INTA_PREFIX, iid_i} : slv_dat;

endmodule

/* verilog/soc_bus_top.sv */
// System bus crossbar top level, one master and four external slaves on loose ports.
// GPIO and the default slave live inside, the processor drives inta_i and iid_i.
`include "soc_bus_consts.svh"

module soc_bus_top import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_lck,

  // Master side
  input  addr_t             m_adr_i,
  input  word_t             m_dat_i,
  input  sel_t              m_sel_i,
  input  logic              m_we_i,
  input  logic              m_cyc_i,
  input  logic              m_stb_i,
  output word_t             m_dat_o,
  output logic              m_ack_o,
  input  logic              inta_i,
  input  logic [`IID_W-1:0] iid_i,

  // Flash
  output addr_t             flash_adr_o,
  output word_t             flash_dat_o,
  output sel_t              flash_sel_o,
  output logic              flash_we_o,
  output logic              flash_cyc_o,
  output logic              flash_stb_o,
  input  word_t             flash_dat_i,
  input  logic              flash_ack_i,

  // Video
  output addr_t             video_adr_o,
  output word_t             video_dat_o,
  output sel_t              video_sel_o,
  output logic              video_we_o,
  output logic              video_cyc_o,
  output logic              video_stb_o,
  input  word_t             video_dat_i,
  input  logic              video_ack_i,

  // Serial port
  output addr_t             uart_adr_o,
  output word_t             uart_dat_o,
  output sel_t              uart_sel_o,
  output logic              uart_we_o,
  output logic              uart_cyc_o,
  output logic              uart_stb_o,
  input  word_t             uart_dat_i,
  input  logic              uart_ack_i,

  // Main memory
  output addr_t             mem_adr_o,
  output word_t             mem_dat_o,
  output sel_t              mem_sel_o,
  output logic              mem_we_o,
  output logic              mem_cyc_o,
  output logic              mem_stb_o,
  input  word_t             mem_dat_i,
  input  logic              mem_ack_i,

  // Board switches and LEDs
  input  logic [`SW_W-1:0]  sw_i,
  output logic [`LED_W-1:0] leds_o
);

  slave_idx_t sel_idx;
  logic       gpio_cyc;
  logic       gpio_stb;
  logic       gpio_ack;
  word_t      gpio_dat;
  logic       def_ack;

  // Shared request fields fan out to every slave
  assign flash_adr_o = m_adr_i;
  assign flash_dat_o = m_dat_i;
  assign flash_sel_o = m_sel_i;
  assign flash_we_o  = m_we_i;
  assign video_adr_o = m_adr_i;
  assign video_dat_o = m_dat_i;
  assign video_sel_o = m_sel_i;
  assign video_we_o  = m_we_i;
  assign uart_adr_o  = m_adr_i;
  assign uart_dat_o  = m_dat_i;
  assign uart_sel_o  = m_sel_i;
  assign uart_we_o   = m_we_i;
  assign mem_adr_o   = m_adr_i;
  assign mem_dat_o   = m_dat_i;
  assign mem_sel_o   = m_sel_i;
  assign mem_we_o    = m_we_i;

  bus_decode u_decode (
    .m_adr_i   (m_adr_i),
    .sel_idx_o (sel_idx)
  );

  bus_route u_route (
    .sel_idx_i   (sel_idx),
    .m_cyc_i     (m_cyc_i),
    .m_stb_i     (m_stb_i),
    .flash_cyc_o (flash_cyc_o),
    .flash_stb_o (flash_stb_o),
    .video_cyc_o (video_cyc_o),
    .video_stb_o (video_stb_o),
    .uart_cyc_o  (uart_cyc_o),
    .uart_stb_o  (uart_stb_o),
    .mem_cyc_o   (mem_cyc_o),
    .mem_stb_o   (mem_stb_o),
    .gpio_cyc_o  (gpio_cyc),
    .gpio_stb_o  (gpio_stb),
    .def_ack_o   (def_ack)
  );

  // Word offset is byte address bit 1, the LSB of the word address
  gpio_regs u_gpio (
    .clk     (clk),
    .rst_lck (rst_lck),
    .cyc_i   (gpio_cyc),
    .stb_i   (gpio_stb),
    .we_i    (m_we_i),
    .adr_i   (m_adr_i[0]),
    .dat_i   (m_dat_i),
    .sw_i    (sw_i),
    .dat_o   (gpio_dat),
    .ack_o   (gpio_ack),
    .leds_o  (leds_o)
  );

  read_return u_return (
    .sel_idx_i   (sel_idx),
    .flash_dat_i (flash_dat_i),
    .flash_ack_i (flash_ack_i),
    .video_dat_i (video_dat_i),
    .video_ack_i (video_ack_i),
    .uart_dat_i  (uart_dat_i),
    .uart_ack_i  (uart_ack_i),
    .mem_dat_i   (mem_dat_i),
    .mem_ack_i   (mem_ack_i),
    .gpio_dat_i  (gpio_dat),
    .gpio_ack_i  (gpio_ack),
    .def_ack_i   (def_ack),
    .inta_i      (inta_i),
    .iid_i       (iid_i),
    .m_dat_o     (m_dat_o),
    .m_ack_o     (m_ack_o)
  );

endmodule

/* verification/tb_soc_bus.sv */
// Random-stimulus testbench of the system bus crossbar.
// Responders on the four external slaves add random wait states, a model predicts the rest.
`include "soc_bus_consts.svh"

module tb_soc_bus import soc_bus_pkg::*; ();

  localparam int NUM_TXN = 400;
  localparam int MAX_CYCLES = NUM_TXN * 6;

  // Address generators, last entry is any I/O address
  localparam addr_t REGION_BASE [8] = '{`FLASH_A, `BIOS_A, `VMEM_A, `VIO_A,
                                        `UART_A, `GPIO_A, `MEM_A, 20'h8_0000};
  localparam addr_t REGION_MASK [8] = '{`FLASH_M, `BIOS_M, `VMEM_M, `VIO_M,
                                        `UART_M, `GPIO_M, `MEM_M, 20'h8_0000};

  logic              clk;
  logic              rst_lck;
  addr_t             m_adr;
  word_t             m_dat;
  sel_t              m_sel;
  logic              m_we;
  logic              m_cyc;
  logic              m_stb;
  word_t             m_rdat;
  logic              m_ack;
  logic              inta;
  logic [`IID_W-1:0] iid;
  logic [`SW_W-1:0]  sw;
  logic [`LED_W-1:0] leds;

  // External slaves 0 flash, 1 video, 2 uart, 3 mem
  addr_t             s_adr [4];
  word_t             s_wdat [4];
  sel_t              s_sel [4];
  logic              s_we [4];
  logic              s_cyc [4];
  logic              s_stb [4];
  word_t             s_rdat [4];
  logic              s_ack [4];

  logic [`LED_W-1:0] leds_model;
  logic [31:0]       lfsr_state = 32'h2919_c45e;
  int                cycles = 0;

  soc_bus_top dut (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .m_adr_i     (m_adr),
    .m_dat_i     (m_dat),
    .m_sel_i     (m_sel),
    .m_we_i      (m_we),
    .m_cyc_i     (m_cyc),
    .m_stb_i     (m_stb),
    .m_dat_o     (m_rdat),
    .m_ack_o     (m_ack),
    .inta_i      (inta),
    .iid_i       (iid),
    .flash_adr_o (s_adr[0]),  .flash_dat_o (s_wdat[0]),
    .flash_sel_o (s_sel[0]),  .flash_we_o  (s_we[0]),
    .flash_cyc_o (s_cyc[0]),  .flash_stb_o (s_stb[0]),
    .flash_dat_i (s_rdat[0]), .flash_ack_i (s_ack[0]),
    .video_adr_o (s_adr[1]),  .video_dat_o (s_wdat[1]),
    .video_sel_o (s_sel[1]),  .video_we_o  (s_we[1]),
    .video_cyc_o (s_cyc[1]),  .video_stb_o (s_stb[1]),
    .video_dat_i (s_rdat[1]), .video_ack_i (s_ack[1]),
    .uart_adr_o  (s_adr[2]),  .uart_dat_o  (s_wdat[2]),
    .uart_sel_o  (s_sel[2]),  .uart_we_o   (s_we[2]),
    .uart_cyc_o  (s_cyc[2]),  .uart_stb_o  (s_stb[2]),
    .uart_dat_i  (s_rdat[2]), .uart_ack_i  (s_ack[2]),
    .mem_adr_o   (s_adr[3]),  .mem_dat_o   (s_wdat[3]),
    .mem_sel_o   (s_sel[3]),  .mem_we_o    (s_we[3]),
    .mem_cyc_o   (s_cyc[3]),  .mem_stb_o   (s_stb[3]),
    .mem_dat_i   (s_rdat[3]), .mem_ack_i   (s_ack[3]),
    .sw_i        (sw),
    .leds_o      (leds)
  );

  // Galois LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic addr_t pick_address();
    logic [31:0] kind;
    logic [31:0] rnd;
    kind = rand_bits(3);
    rnd = rand_bits(20);
    return REGION_BASE[kind[2:0]] | (rnd[19:0] & ~REGION_MASK[kind[2:0]]);
  endfunction

  function automatic logic in_region(input addr_t adr, input addr_t base, input addr_t mask);
    return (adr & mask) == (base & mask);
  endfunction

  // Reference memory map, first match wins
  function automatic slave_idx_t model_owner(input addr_t adr);
    if (in_region(adr, `FLASH_A, `FLASH_M) || in_region(adr, `BIOS_A, `BIOS_M)) begin
      return SLV_FLASH;
    end
    if (in_region(adr, `VMEM_A, `VMEM_M) || in_region(adr, `VIO_A, `VIO_M)) begin
      return SLV_VIDEO;
    end
    if (in_region(adr, `UART_A, `UART_M)) begin
      return SLV_UART;
    end
    if (in_region(adr, `GPIO_A, `GPIO_M)) begin
      return SLV_GPIO;
    end
    if (in_region(adr, `MEM_A, `MEM_M)) begin
      return SLV_MEM;
    end
    return SLV_DEFAULT;
  endfunction

  // Position in the responder arrays, -1 for the internal slaves
  function automatic int ext_index(input slave_idx_t idx);
    case (idx)
      SLV_FLASH: return 0;
      SLV_VIDEO: return 1;
      SLV_UART:  return 2;
      SLV_MEM:   return 3;
      default:   return -1;
    endcase
  endfunction

  function automatic string slave_name(input int i);
    case (i)
      0:       return "flash";
      1:       return "video";
      2:       return "uart";
      default: return "mem";
    endcase
  endfunction

  function automatic word_t expected_read(input slave_idx_t idx, input int ext);
    if (inta) begin
      return {`INTA_PREFIX, iid};
    end
    if (ext >= 0) begin
      return s_rdat[ext];
    end
    if (idx == SLV_GPIO) begin
      return m_adr[0] ? word_t'(leds_model) : word_t'(sw);
    end
    return `DEFAULT_DATA;
  endfunction

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Request fields reach every slave, cycle and strobe only the owner
  task automatic check_routing(input int ext);
    for (int i = 0; i < 4; i++) begin
      check_value({slave_name(i), "_adr_o"}, 32'(s_adr[i]), 32'(m_adr));
      check_value({slave_name(i), "_dat_o"}, 32'(s_wdat[i]), 32'(m_dat));
      check_value({slave_name(i), "_sel_o"}, 32'(s_sel[i]), 32'(m_sel));
      check_value({slave_name(i), "_we_o"}, 32'(s_we[i]), 32'(m_we));
      check_value({slave_name(i), "_cyc_o"}, 32'(s_cyc[i]), 32'((i == ext) && m_cyc));
      check_value({slave_name(i), "_stb_o"}, 32'(s_stb[i]), 32'((i == ext) && m_stb));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    if (rst_lck) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
        $display("timeout: transactions did not complete within %0d cycles", MAX_CYCLES);
        abort_run();
      end
    end
  end

  // External slave responders, 0 to 3 wait cycles then random read data
  initial begin
    logic        busy [4];
    logic [1:0]  wait_left [4];
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++) begin
      busy[i] = 1'b0;
      wait_left[i] = 2'd0;
      s_ack[i] = 1'b0;
      s_rdat[i] = '0;
    end
    forever begin
      @(posedge clk);
      #2;
      for (int i = 0; i < 4; i++) begin
        // Transfer finished at this edge
        if (s_ack[i]) begin
          s_ack[i] = 1'b0;
          busy[i] = 1'b0;
        end
        if (s_cyc[i] && s_stb[i] && !busy[i]) begin
          busy[i] = 1'b1;
          rnd = rand_bits(2);
          wait_left[i] = rnd[1:0];
        end else if (busy[i]) begin
          wait_left[i] = wait_left[i] - 2'd1;
        end
        if (busy[i] && wait_left[i] == 2'd0) begin
          rnd = rand_bits(16);
          s_rdat[i] = rnd[15:0];
          s_ack[i] = 1'b1;
        end
      end
    end
  end

  initial begin
    logic [31:0] rnd;
    slave_idx_t  exp_idx;
    int          ext;
    logic        exp_ack;
    logic        done;
    rst_lck = 1'b0;
    m_adr = '0;
    m_dat = '0;
    m_sel = '0;
    m_we = 1'b0;
    m_cyc = 1'b0;
    m_stb = 1'b0;
    inta = 1'b0;
    iid = '0;
    sw = '0;
    leds_model = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_lck = 1'b1;
    @(negedge clk);
    check_value("leds_o", 32'(leds), 32'(0));

    for (int t = 0; t < NUM_TXN; t++) begin
      @(posedge clk);
      #1;
      rnd = rand_bits(2);
      if (rnd[1:0] == 2'd0) begin
        // Strobe low for a cycle while cycle may stay high
        rnd = rand_bits(1);
        m_cyc = rnd[0];
        m_stb = 1'b0;
        m_adr = pick_address();
        @(negedge clk);
        check_routing(ext_index(model_owner(m_adr)));
        check_value("m_ack_o", 32'(m_ack), 32'(0));
        @(posedge clk);
        #1;
      end
      m_adr = pick_address();
      rnd = rand_bits(16);
      m_dat = rnd[15:0];
      rnd = rand_bits(2);
      m_sel = rnd[1:0];
      rnd = rand_bits(1);
      m_we = rnd[0];
      rnd = rand_bits(3);
      inta = (rnd[2:0] == 3'd0);
      rnd = rand_bits(3);
      iid = rnd[2:0];
      rnd = rand_bits(10);
      sw = rnd[9:0];
      m_cyc = 1'b1;
      m_stb = 1'b1;
      exp_idx = model_owner(m_adr);
      ext = ext_index(exp_idx);
      done = 1'b0;

      // Request held until the acknowledge
      while (!done) begin
        @(negedge clk);
        check_routing(ext);
        check_value("leds_o", 32'(leds), 32'(leds_model));
        exp_ack = (ext >= 0) ? s_ack[ext] : 1'b1;
        check_value("m_ack_o", 32'(m_ack), 32'(exp_ack));
        if (m_ack) begin
          done = 1'b1;
          if (!m_we || inta) begin
            check_value("m_dat_o", 32'(m_rdat), 32'(expected_read(exp_idx, ext)));
          end
          // LED register loads at the acknowledging edge
          if (exp_idx == SLV_GPIO && m_we && m_adr[0]) begin
            leds_model = m_dat[`LED_W-1:0];
          end
        end
      end
    end

    @(posedge clk);
    #1;
    m_cyc = 1'b0;
    m_stb = 1'b0;
    @(negedge clk);
    check_value("leds_o", 32'(leds), 32'(leds_model));

    // Synchronous reset clears the LED register
    @(posedge clk);
    #1;
    rst_lck = 1'b0;
    leds_model = '0;
    @(posedge clk);
    @(negedge clk);
    check_value("leds_o", 32'(leds), 32'(leds_model));
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* sources.f */
+incdir+verilog
verilog/soc_bus_pkg.sv
verilog/bus_decode.sv
verilog/bus_route.sv
verilog/gpio_regs.sv
verilog/read_return.sv
verilog/soc_bus_top.sv
verification/tb_soc_bus.sv

/* Makefile */
# Verilator simulation of the system bus crossbar testbench

.PHONY: sim clean

sim:
	verilator --binary --assert -f sources.f --top-module tb_soc_bus -Mdir obj_dir
	./obj_dir/Vtb_soc_bus

clean:
	rm -rf obj_dir
